// ==== verilog/trk_cfg.svh ====
// Track output path configuration
`ifndef TRK_CFG_SVH
`define TRK_CFG_SVH

// ==========================================================
// Data widths
// ==========================================================
// Q16.16 fixed-point word
`define TRK_FP_W          32
`define TRK_TGT_ID_W      3
`define TRK_STREAM_ID_W   2

// ==========================================================
// Register map
// ==========================================================
`define TRK_ADDR_W        12
`define TRK_REG_CTRL      12'h000
`define TRK_REG_RATE      12'h008
`define TRK_REG_STREAM_SEL 12'h00C

// Reset rate of 10 per second for a 0.1 s sample interval
`define TRK_RATE_RESET    32'h000A_0000
// Pattern returned for unmapped reads
`define TRK_READ_INVALID  32'hDEAD_BEEF

// Samples between a forward estimate and its replay
`define TRK_LAG_DEPTH     4

`endif

// ==== verilog/trk_pkg.sv ====
// Track output path types
`include "trk_cfg.svh"

package trk_pkg;

    // ==========================================================
    // Scalar and measurement types
    // ==========================================================
    // Signed Q16.16
    typedef logic signed [`TRK_FP_W-1:0] fp_t;

    // Input word with target id on top
    typedef struct packed {
        logic [`TRK_TGT_ID_W-1:0] tgt_id;
        fp_t                      y;
        fp_t                      x;
    } meas_t;

    // One track estimate
    typedef struct packed {
        logic [`TRK_TGT_ID_W-1:0] tgt_id;
        fp_t                      quality;
        fp_t                      vy;
        fp_t                      vx;
        fp_t                      y;
        fp_t                      x;
    } trk_est_t;

    // ==========================================================
    // Output stream
    // ==========================================================
    // Codes 2 and 3 are unused and fall back to forward
    typedef enum logic [`TRK_STREAM_ID_W-1:0] {
        STREAM_FWD = 2'd0,
        STREAM_LAG = 2'd1
    } stream_id_e;

    typedef struct packed {
        stream_id_e stream_id;
        trk_est_t   est;
    } trk_out_t;

    // Control register layout
    typedef struct packed {
        logic [29:0] rsvd;
        logic        sys_reset;
        logic        sys_enable;
    } cfg_ctrl_t;

    // Write word seen as control bits or as a fixed-point value
    typedef union packed {
        cfg_ctrl_t ctrl;
        fp_t       raw;
    } cfg_word_u;

endpackage

// ==== verilog/trk_cfg_regs.sv ====
// Track configuration registers
`timescale 1ns/1ps
`include "trk_cfg.svh"

module trk_cfg_regs
    import trk_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`TRK_ADDR_W-1:0] cfg_addr,
    input  cfg_word_u              cfg_wdata,
    input  logic                   cfg_wen,
    input  logic                   cfg_ren,
    output logic [`TRK_FP_W-1:0]   cfg_rdata,
    output logic                   sys_enable,
    output logic                   sys_reset,
    output fp_t                    cfg_rate,
    output stream_id_e             stream_sel
);

    // ==========================================================
    // Write decode
    // ==========================================================
    // Takes effect on the cycle cfg_wen is sampled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sys_enable <= 1'b0;
            sys_reset  <= 1'b0;
            cfg_rate   <= `TRK_RATE_RESET;
            stream_sel <= STREAM_FWD;
        end else if (cfg_wen) begin
            case (cfg_addr)
                // Control view of the write word
                `TRK_REG_CTRL: begin
                    sys_enable <= cfg_wdata.ctrl.sys_enable;
                    sys_reset  <= cfg_wdata.ctrl.sys_reset;
                end
                // Fixed-point view for the rate
                `TRK_REG_RATE: cfg_rate <= cfg_wdata.raw;
                // Raw code kept and resolved at the output when unknown
                `TRK_REG_STREAM_SEL: begin
                    stream_sel <= stream_id_e'(cfg_wdata.raw[`TRK_STREAM_ID_W-1:0]);
                end
                default: ;
            endcase
        end
    end

    // ==========================================================
    // Readback
    // ==========================================================
    // Updated one cycle after cfg_ren and held otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_rdata <= '0;
        end else if (cfg_ren) begin
            case (cfg_addr)
                `TRK_REG_CTRL:       cfg_rdata <= {30'b0, sys_reset, sys_enable};
                `TRK_REG_RATE:       cfg_rdata <= cfg_rate;
                `TRK_REG_STREAM_SEL: begin
                    cfg_rdata <= {{(`TRK_FP_W-`TRK_STREAM_ID_W){1'b0}}, stream_sel};
                end
                default:             cfg_rdata <= `TRK_READ_INVALID;
            endcase
        end
    end

    // Control write then read gives back the written bits over zero reserved bits
    property p_ctrl_rsvd_zero;
        @(posedge clk) disable iff (!rst_n)
        (cfg_wen && cfg_addr == `TRK_REG_CTRL) ##1 (cfg_ren && cfg_addr == `TRK_REG_CTRL)
        |=> (cfg_rdata == {30'b0, $past(cfg_wdata.ctrl.sys_reset, 2),
                           $past(cfg_wdata.ctrl.sys_enable, 2)});
    endproperty
    a_ctrl_rsvd_zero: assert property (p_ctrl_rsvd_zero)
        else $error("control readback differs from the written control bits");

endmodule

// ==== verilog/trk_cv_estimator.sv ====
// Constant-velocity difference estimator
`timescale 1ns/1ps
`include "trk_cfg.svh"

module trk_cv_estimator
    import trk_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  meas_t    meas_tdata,
    input  logic     meas_tvalid,
    output logic     meas_tready,
    input  logic     sys_enable,
    input  logic     sys_reset,
    input  fp_t      cfg_rate,
    output trk_est_t est,
    output logic     est_valid
);

    // Fraction bits of Q16.16
    localparam int FRAC = 16;

    logic                          accept;
    logic                          have_hist;
    fp_t                           prev_x;
    fp_t                           prev_y;
    fp_t                           prev_dx;
    fp_t                           prev_dy;
    fp_t                           dx;
    fp_t                           dy;
    fp_t                           ddx;
    fp_t                           ddy;
    logic signed [2*`TRK_FP_W-1:0] prod_x;
    logic signed [2*`TRK_FP_W-1:0] prod_y;

    // ==========================================================
    // Acceptance
    // ==========================================================
    assign meas_tready = sys_enable;
    assign accept      = meas_tvalid & sys_enable & ~sys_reset;

    // Steps and step changes
    always_comb begin
        // Zero step on the first sample after a reset
        dx  = have_hist ? fp_t'(meas_tdata.x - prev_x) : '0;
        dy  = have_hist ? fp_t'(meas_tdata.y - prev_y) : '0;
        ddx = dx - prev_dx;
        ddy = dy - prev_dy;
        // Full signed product rescaled back to Q16.16
        prod_x = dx * cfg_rate;
        prod_y = dy * cfg_rate;
    end

    // ==========================================================
    // History
    // ==========================================================
    // Soft reset clears it while set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_hist <= 1'b0;
            prev_dx   <= '0;
            prev_dy   <= '0;
        end else if (sys_reset) begin
            have_hist <= 1'b0;
            prev_dx   <= '0;
            prev_dy   <= '0;
        end else if (accept) begin
            have_hist <= 1'b1;
            prev_dx   <= dx;
            prev_dy   <= dy;
        end
    end

    // Only meaningful with have_hist set
    always_ff @(posedge clk) begin
        if (accept) begin
            prev_x <= meas_tdata.x;
            prev_y <= meas_tdata.y;
        end
    end

    // ==========================================================
    // Estimate register
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            est_valid <= 1'b0;
        end else begin
            est_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            est.tgt_id  <= meas_tdata.tgt_id;
            est.x       <= meas_tdata.x;
            est.y       <= meas_tdata.y;
            est.vx      <= prod_x[FRAC +: `TRK_FP_W];
            est.vy      <= prod_y[FRAC +: `TRK_FP_W];
            // Absolute step change standing in for NIS
            est.quality <= (ddx[`TRK_FP_W-1] ? -ddx : ddx)
                         + (ddy[`TRK_FP_W-1] ? -ddy : ddy);
        end
    end

    // First estimate after a reset carries no motion
    a_first_est_still: assert property (
        @(posedge clk) disable iff (!rst_n)
        est_valid && $past(!have_hist)
            |-> (est.vx == '0 && est.vy == '0 && est.quality == '0)
    ) else $error("first estimate after a reset has nonzero motion");

endmodule

// ==== verilog/trk_lag_line.sv ====
// Fixed-lag estimate replay line
`timescale 1ns/1ps
`include "trk_cfg.svh"

module trk_lag_line
    import trk_pkg::*;
#(
    parameter int DEPTH = `TRK_LAG_DEPTH
)(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     sys_reset,
    input  trk_est_t est,
    input  logic     est_valid,
    output trk_est_t lag_est,
    output logic     lag_valid
);

    localparam int FILL_W = $clog2(DEPTH + 1);

    // Entry 0 is the newest
    trk_est_t          line_q [DEPTH];
    logic [FILL_W-1:0] fill;
    logic              full;

    assign full = (fill == FILL_W'(DEPTH));

    // ==========================================================
    // Fill tracking
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill      <= '0;
            lag_valid <= 1'b0;
        end else if (sys_reset) begin
            // Needs DEPTH new estimates before replay resumes
            fill      <= '0;
            lag_valid <= 1'b0;
        end else begin
            lag_valid <= est_valid & full;
            if (est_valid && !full) begin
                fill <= fill + 1'b1;
            end
        end
    end

    // ==========================================================
    // Shift and replay
    // ==========================================================
    // Oldest entry leaves as the new one enters
    always_ff @(posedge clk) begin
        if (est_valid) begin
            lag_est   <= line_q[DEPTH-1];
            line_q[0] <= est;
            for (int i = 1; i < DEPTH; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // Replay only from a full line whose count stops at the depth
    a_lag_only_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fill <= FILL_W'(DEPTH)) && (!lag_valid || full)
    ) else $error("lag_valid while the line was not full");

endmodule

// ==== verilog/trk_stream_out.sv ====
// Track output stream select and register
`timescale 1ns/1ps

module trk_stream_out
    import trk_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  stream_id_e stream_sel,
    input  trk_est_t   est,
    input  logic       est_valid,
    input  trk_est_t   lag_est,
    input  logic       lag_valid,
    input  logic       trk_tready,
    output trk_out_t   trk_tdata,
    output logic       trk_tvalid
);

    trk_est_t   sel_est;
    logic       sel_valid;
    stream_id_e sel_id;

    // ==========================================================
    // Stream mux
    // ==========================================================
    always_comb begin
        case (stream_sel)
            STREAM_LAG: begin
                sel_est   = lag_est;
                sel_valid = lag_valid;
                sel_id    = STREAM_LAG;
            end
            // Forward for unknown codes too
            default: begin
                sel_est   = est;
                sel_valid = est_valid;
                sel_id    = STREAM_FWD;
            end
        endcase
    end

    // ==========================================================
    // Output register
    // ==========================================================
    // Item dropped when ready is low at capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trk_tvalid <= 1'b0;
        end else begin
            trk_tvalid <= sel_valid & trk_tready;
        end
    end

    // Data captured even when the item is dropped
    always_ff @(posedge clk) begin
        if (sel_valid) begin
            trk_tdata <= '{stream_id: sel_id, est: sel_est};
        end
    end

    // Output id names the stream whose pulse was captured with ready high
    a_tvalid_after_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        trk_tvalid |-> $past(trk_tready)
            && (trk_tdata.stream_id == STREAM_LAG ? $past(lag_valid) : $past(est_valid))
    ) else $error("trk_tvalid without ready or without a pulse on its stream");

endmodule

// ==== verilog/trk_top.sv ====
// Radar track output path top level
`timescale 1ns/1ps
`include "trk_cfg.svh"

module trk_top
    import trk_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // Measurement input
    input  meas_t                  meas_tdata,
    input  logic                   meas_tvalid,
    output logic                   meas_tready,
    // Track output
    output trk_out_t               trk_tdata,
    output logic                   trk_tvalid,
    input  logic                   trk_tready,
    // Register port
    input  logic [`TRK_ADDR_W-1:0] cfg_addr,
    input  cfg_word_u              cfg_wdata,
    input  logic                   cfg_wen,
    input  logic                   cfg_ren,
    output logic [`TRK_FP_W-1:0]   cfg_rdata,
    output logic                   ready
);

    logic       sys_enable;
    logic       sys_reset;
    fp_t        cfg_rate;
    stream_id_e stream_sel;
    trk_est_t   est;
    logic       est_valid;
    trk_est_t   lag_est;
    logic       lag_valid;

    // Enabled and not held in soft reset
    assign ready = sys_enable & ~sys_reset;

    // ==========================================================
    // Decode
    // ==========================================================
    trk_cfg_regs trk_cfg_regs_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_wen    (cfg_wen),
        .cfg_ren    (cfg_ren),
        .cfg_rdata  (cfg_rdata),
        .sys_enable (sys_enable),
        .sys_reset  (sys_reset),
        .cfg_rate   (cfg_rate),
        .stream_sel (stream_sel)
    );

    // ==========================================================
    // Execute
    // ==========================================================
    trk_cv_estimator trk_cv_estimator_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .meas_tdata  (meas_tdata),
        .meas_tvalid (meas_tvalid),
        .meas_tready (meas_tready),
        .sys_enable  (sys_enable),
        .sys_reset   (sys_reset),
        .cfg_rate    (cfg_rate),
        .est         (est),
        .est_valid   (est_valid)
    );

    trk_lag_line #(
        .DEPTH (`TRK_LAG_DEPTH)
    ) trk_lag_line_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sys_reset (sys_reset),
        .est       (est),
        .est_valid (est_valid),
        .lag_est   (lag_est),
        .lag_valid (lag_valid)
    );

    // ==========================================================
    // Result
    // ==========================================================
    trk_stream_out trk_stream_out_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .stream_sel (stream_sel),
        .est        (est),
        .est_valid  (est_valid),
        .lag_est    (lag_est),
        .lag_valid  (lag_valid),
        .trk_tready (trk_tready),
        .trk_tdata  (trk_tdata),
        .trk_tvalid (trk_tvalid)
    );

endmodule

// ==== sim/trk_tb.sv ====
// Track output path testbench
`timescale 1ns/1ps
`include "trk_cfg.svh"

module trk_tb
    import trk_pkg::*;
();

    localparam int NROWS = 8;
    // Rows times 4 cycles times 10 ns times 6 tests times 2
    localparam int WATCHDOG_NS = NROWS * 4 * 10 * 6 * 2;
    // 2.5 per second
    localparam logic [`TRK_FP_W-1:0] RATE_TEST = 32'h0002_8000;

    logic                   clk = 1'b0;
    logic                   rst_n;
    meas_t                  meas_tdata;
    logic                   meas_tvalid;
    logic                   meas_tready;
    trk_out_t               trk_tdata;
    logic                   trk_tvalid;
    logic                   trk_tready;
    logic [`TRK_ADDR_W-1:0] cfg_addr;
    cfg_word_u              cfg_wdata;
    logic                   cfg_wen;
    logic                   cfg_ren;
    logic [`TRK_FP_W-1:0]   cfg_rdata;
    logic                   ready;

    // Measurement rows of x, y and target id in whole units
    int rows [NROWS][3] = '{
        '{10, -4, 1}, '{13, -2, 1}, '{17, -1, 2}, '{20, 3, 2},
        '{22, 6, 3}, '{27, 5, 4}, '{31, 9, 5}, '{30, 14, 6}
    };

    int         checks = 0;
    int         errors = 0;
    int         err0;
    stream_id_e cur_sel = STREAM_FWD;

    // Reference model state
    bit       m_have;
    fp_t      m_px;
    fp_t      m_py;
    fp_t      m_pdx;
    fp_t      m_pdy;
    fp_t      m_rate;
    trk_est_t lag_q [$];

    trk_top trk_top_inst (.*);

    always #5 clk = ~clk;

    // ==========================================================
    // Checks and reference model
    // ==========================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input int num, input string name, input int start_errs);
        if (errors == start_errs) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: FAIL with %0d errors", num, name, errors - start_errs);
        end
    endtask

    function automatic fp_t abs_fp(input fp_t v);
        return (v < 0) ? -v : v;
    endfunction

    // History cleared as after reset or soft reset
    task automatic model_reset();
        m_have = 1'b0;
        m_pdx  = '0;
        m_pdy  = '0;
        lag_q.delete();
    endtask

    // Difference estimate of one accepted measurement
    task automatic model_accept(input meas_t m, output trk_est_t e);
        fp_t    dx;
        fp_t    dy;
        longint prod;
        dx = m_have ? fp_t'(m.x - m_px) : '0;
        dy = m_have ? fp_t'(m.y - m_py) : '0;
        e.x      = m.x;
        e.y      = m.y;
        e.tgt_id = m.tgt_id;
        prod = longint'(dx) * longint'(m_rate);
        e.vx = fp_t'(prod >>> 16);
        prod = longint'(dy) * longint'(m_rate);
        e.vy = fp_t'(prod >>> 16);
        e.quality = abs_fp(dx - m_pdx) + abs_fp(dy - m_pdy);
        m_have = 1'b1;
        m_px   = m.x;
        m_py   = m.y;
        m_pdx  = dx;
        m_pdy  = dy;
    endtask

    // ==========================================================
    // Register port
    // ==========================================================
    task automatic reg_write(input logic [`TRK_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        cfg_addr      <= addr;
        cfg_wdata.raw <= data;
        cfg_wen       <= 1'b1;
        @(posedge clk);
        cfg_wen <= 1'b0;
    endtask

    task automatic reg_check(input logic [`TRK_ADDR_W-1:0] addr, input logic [31:0] exp,
                             input string name);
        @(posedge clk);
        cfg_addr <= addr;
        cfg_ren  <= 1'b1;
        @(posedge clk);
        cfg_ren <= 1'b0;
        @(negedge clk);
        check_value(name, cfg_rdata, exp);
    endtask

    task automatic select_stream(input stream_id_e s);
        reg_write(`TRK_REG_STREAM_SEL, 32'(s));
        cur_sel = s;
    endtask

    // Soft reset pulse with ready low while it is set
    task automatic soft_reset();
        reg_write(`TRK_REG_CTRL, 32'h3);
        @(negedge clk);
        check_value("ready", 32'(ready), 32'h0);
        reg_write(`TRK_REG_CTRL, 32'h1);
        model_reset();
    endtask

    // ==========================================================
    // One table row over 4 cycles
    // ==========================================================
    task automatic apply_row(input int idx, input bit accepted, input bit rdy);
        meas_t    m;
        trk_est_t fwd;
        trk_est_t lagged;
        trk_out_t want;
        trk_out_t got;
        bit       have_lag;
        bit       due;
        int       exp_lat;
        int       seen;
        m.x      = fp_t'(rows[idx][0] * 65536);
        m.y      = fp_t'(rows[idx][1] * 65536);
        m.tgt_id = 3'(rows[idx][2]);
        fwd      = '0;
        lagged   = '0;
        got      = '0;
        have_lag = 1'b0;
        if (accepted) begin
            model_accept(m, fwd);
            lag_q.push_back(fwd);
            // Replay of the estimate DEPTH rows back
            if (lag_q.size() > `TRK_LAG_DEPTH) begin
                lagged   = lag_q.pop_front();
                have_lag = 1'b1;
            end
        end
        if (cur_sel == STREAM_LAG) begin
            due            = have_lag & rdy;
            want.stream_id = STREAM_LAG;
            want.est       = lagged;
            exp_lat        = 3;
        end else begin
            due            = accepted & rdy;
            want.stream_id = STREAM_FWD;
            want.est       = fwd;
            exp_lat        = 2;
        end
        @(posedge clk);
        meas_tdata  <= m;
        meas_tvalid <= 1'b1;
        trk_tready  <= rdy;
        @(posedge clk);
        meas_tvalid <= 1'b0;
        seen = 0;
        // Cycles counted from the acceptance edge
        for (int c = 1; c <= 3; c++) begin
            @(negedge clk);
            if (trk_tvalid && seen == 0) begin
                seen = c;
                got  = trk_tdata;
            end
        end
        if (due && seen == 0) begin
            errors++;
            $display("row %0d: no output when one was due", idx);
        end else if (!due && seen != 0) begin
            errors++;
            $display("row %0d: output appeared when none was due", idx);
        end else if (due) begin
            check_value("trk_tvalid latency", 32'(seen), 32'(exp_lat));
            check_value("trk_tdata.stream_id", 32'(got.stream_id), 32'(want.stream_id));
            check_value("trk_tdata.est.tgt_id", 32'(got.est.tgt_id), 32'(want.est.tgt_id));
            check_value("trk_tdata.est.x", got.est.x, want.est.x);
            check_value("trk_tdata.est.y", got.est.y, want.est.y);
            check_value("trk_tdata.est.vx", got.est.vx, want.est.vx);
            check_value("trk_tdata.est.vy", got.est.vy, want.est.vy);
            check_value("trk_tdata.est.quality", got.est.quality, want.est.quality);
        end
        // Dropped item still lands in the data register
        if (accepted && !rdy && cur_sel == STREAM_FWD) begin
            check_value("trk_tdata.est.x (dropped)", trk_tdata.est.x, fwd.x);
        end
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        rst_n       = 1'b0;
        meas_tdata  = '0;
        meas_tvalid = 1'b0;
        trk_tready  = 1'b1;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        cfg_wen     = 1'b0;
        cfg_ren     = 1'b0;
        m_rate      = `TRK_RATE_RESET;
        model_reset();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Defaults, readback and the unmapped pattern
        err0 = errors;
        reg_check(`TRK_REG_CTRL, 32'h0, "cfg_rdata (ctrl)");
        reg_check(`TRK_REG_RATE, `TRK_RATE_RESET, "cfg_rdata (rate)");
        reg_check(`TRK_REG_STREAM_SEL, 32'h0, "cfg_rdata (stream_sel)");
        reg_write(`TRK_REG_RATE, RATE_TEST);
        m_rate = RATE_TEST;
        reg_check(`TRK_REG_RATE, RATE_TEST, "cfg_rdata (rate)");
        select_stream(STREAM_LAG);
        reg_check(`TRK_REG_STREAM_SEL, 32'h1, "cfg_rdata (stream_sel)");
        select_stream(STREAM_FWD);
        reg_check(12'h010, `TRK_READ_INVALID, "cfg_rdata (unmapped)");
        end_test(1, "registers", err0);

        // Disabled input
        err0 = errors;
        @(negedge clk);
        check_value("meas_tready", 32'(meas_tready), 32'h0);
        check_value("ready", 32'(ready), 32'h0);
        apply_row(0, 1'b0, 1'b1);
        end_test(2, "disabled input", err0);

        // Forward stream over the whole table
        err0 = errors;
        reg_write(`TRK_REG_CTRL, 32'h1);
        reg_check(`TRK_REG_CTRL, 32'h1, "cfg_rdata (ctrl)");
        check_value("meas_tready", 32'(meas_tready), 32'h1);
        check_value("ready", 32'(ready), 32'h1);
        for (int i = 0; i < NROWS; i++) begin
            apply_row(i, 1'b1, 1'b1);
        end
        end_test(3, "forward stream", err0);

        // Lag stream from an empty line
        err0 = errors;
        soft_reset();
        select_stream(STREAM_LAG);
        for (int i = 0; i < NROWS; i++) begin
            apply_row(i, 1'b1, 1'b1);
        end
        end_test(4, "lag stream", err0);

        // Soft reset mid-stream with zero motion on the first row back
        err0 = errors;
        select_stream(STREAM_FWD);
        soft_reset();
        apply_row(0, 1'b1, 1'b1);
        select_stream(STREAM_LAG);
        for (int i = 1; i < NROWS; i++) begin
            apply_row(i, 1'b1, 1'b1);
        end
        end_test(5, "soft reset", err0);

        // Output ready low at capture
        err0 = errors;
        select_stream(STREAM_FWD);
        apply_row(1, 1'b1, 1'b0);
        apply_row(2, 1'b1, 1'b1);
        end_test(6, "output ready low", err0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("tests failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/trk_pkg.sv
verilog/trk_cfg_regs.sv
verilog/trk_cv_estimator.sv
verilog/trk_lag_line.sv
verilog/trk_stream_out.sv
verilog/trk_top.sv
sim/trk_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
verilator --binary --timing --assert --top-module trk_tb -f project.f \
    -Mdir obj_dir -o trk_sim \
    && ./obj_dir/trk_sim | tee /dev/stderr | grep -qx "all tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
